/* hdl/deframe.sv */
`timescale 1ns/1ns

module deframe
    import uart_rx_pkg::*;
(
    input  logic                  baud_clk,
    input  logic                  reset_n,
    input  logic                  recieved_flag,
    input  logic [FRAME_BITS-1:0] data_parll,
    input  logic                  parity_error,
    output logic                  data_valid,
    output logic [DATA_BITS-1:0]  rx_data,
    output logic                  parity_err_flag,
    output logic                  frame_err_flag
);

    // Delayed copy for edge detection
    logic recieved_d;
    // First cycle of a new frame handoff
    logic frame_rise;

    assign frame_rise = recieved_flag & ~recieved_d;

    always_ff @(posedge baud_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            recieved_d      <= 1'b0;
            data_valid      <= 1'b0;
            parity_err_flag <= 1'b0;
            frame_err_flag  <= 1'b0;
        end
        else
        begin
            recieved_d <= recieved_flag;
            data_valid <= frame_rise;
            if (frame_rise)
            begin
                parity_err_flag <= parity_error;
                // Start must read low and stop must read high
                frame_err_flag  <= data_parll[0] | ~data_parll[FRAME_BITS-1];
            end
        end
    end

    // Data byte latched with the flags and held until the next frame
    always_ff @(posedge baud_clk)
    begin
        if (frame_rise)
        begin
            rx_data <= data_parll[DATA_BITS:1];
        end
    end

    // One pulse per frame
    a_valid_single: assert property (
        @(posedge baud_clk) disable iff (!reset_n)
        data_valid |=> !data_valid
    );

endmodule

/* hdl/parity_check.sv */
`timescale 1ns/1ns

module parity_check
    import uart_rx_pkg::*;
(
    // Frame as captured by the shift register
    input  logic [FRAME_BITS-1:0] data_parll,
    input  parity_mode_t          parity_mode,
    output logic                  parity_error
);

    // XOR of the data bits and the parity bit
    logic parity_sum;

    // Data sits in bits 1..8, parity in bit 9
    assign parity_sum = ^data_parll[DATA_BITS+1:1];

    always_comb
    begin
        case (parity_mode)
            // Even parity expects an even count of ones
            PARITY_EVEN:
            begin
                parity_error = parity_sum;
            end
            // Odd parity expects an odd count of ones
            PARITY_ODD:
            begin
                parity_error = ~parity_sum;
            end
            default:
            begin
                parity_error = 1'b1;
            end
        endcase
    end

endmodule

/* hdl/rx_error_stats.sv */
`timescale 1ns/1ns

module rx_error_stats
    import uart_rx_pkg::*;
(
    input  logic                  baud_clk,
    input  logic                  reset_n,
    input  logic                  data_valid,
    input  logic                  parity_err_flag,
    input  logic                  frame_err_flag,
    output logic [STAT_WIDTH-1:0] frame_count,
    output logic [STAT_WIDTH-1:0] parity_err_count,
    output logic [STAT_WIDTH-1:0] frame_err_count
);

    // Increment that sticks at all ones
    function automatic logic [STAT_WIDTH-1:0] sat_inc(input logic [STAT_WIDTH-1:0] count);
        if (&count)
        begin
            return count;
        end
        return count + 1'b1;
    endfunction

    always_ff @(posedge baud_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            frame_count      <= '0;
            parity_err_count <= '0;
            frame_err_count  <= '0;
        end
        else if (data_valid)
        begin
            frame_count <= sat_inc(frame_count);
            if (parity_err_flag)
            begin
                parity_err_count <= sat_inc(parity_err_count);
            end
            if (frame_err_flag)
            begin
                frame_err_count <= sat_inc(frame_err_count);
            end
        end
    end

    // A full counter stays full until reset
    property p_no_wrap(logic [STAT_WIDTH-1:0] count);
        @(posedge baud_clk) disable iff (!reset_n)
        (&count) |=> (&count);
    endproperty

    a_frame_sat:  assert property (p_no_wrap(frame_count));
    a_parity_sat: assert property (p_no_wrap(parity_err_count));
    a_ferr_sat:   assert property (p_no_wrap(frame_err_count));

endmodule

/* hdl/sipo.sv */
`timescale 1ns/1ns

module sipo
    import uart_rx_pkg::*;
(
    input  logic                  baud_clk,
    input  logic                  reset_n,
    // Serial line idles high
    input  logic                  data_tx,
    output logic                  active_flag,
    output logic                  recieved_flag,
    // Captured frame with the start bit in bit 0
    output logic [FRAME_BITS-1:0] data_parll
);

    rx_state_t state;

    // Oversample counter inside one bit period
    logic [OS_WIDTH-1:0] os_count;
    // Index of the last captured bit
    logic [BIT_WIDTH-1:0] bit_count;

    always_ff @(posedge baud_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state         <= IDLE;
            os_count      <= '0;
            bit_count     <= '0;
            active_flag   <= 1'b0;
            recieved_flag <= 1'b0;
            data_parll    <= '1;
        end
        else
        begin
            case (state)
                // Wait for the falling edge of the start bit
                IDLE:
                begin
                    data_parll    <= '1;
                    os_count      <= '0;
                    bit_count     <= '0;
                    recieved_flag <= 1'b0;
                    if (!data_tx)
                    begin
                        state       <= CENTER;
                        active_flag <= 1'b1;
                    end
                    else
                    begin
                        active_flag <= 1'b0;
                    end
                end

                // Move the sample point to the middle of the start bit
                CENTER:
                begin
                    if (os_count == OS_WIDTH'(HALF_BIT - 1))
                    begin
                        data_parll[0] <= data_tx;
                        os_count      <= '0;
                        state         <= FRAME;
                    end
                    else
                    begin
                        os_count <= os_count + 1'b1;
                    end
                end

                // One sample per bit period for the remaining ten bits
                FRAME:
                begin
                    if (bit_count == BIT_WIDTH'(FRAME_BITS - 1))
                    begin
                        // Stop bit already captured
                        bit_count     <= '0;
                        recieved_flag <= 1'b1;
                        state         <= HOLD;
                    end
                    else if (os_count == OS_WIDTH'(OVERSAMPLE - 1))
                    begin
                        data_parll[bit_count + 1'b1] <= data_tx;
                        bit_count                    <= bit_count + 1'b1;
                        os_count                     <= '0;
                    end
                    else
                    begin
                        os_count <= os_count + 1'b1;
                    end
                end

                // Keep the frame on the outputs for one bit period
                HOLD:
                begin
                    if (os_count == OS_WIDTH'(OVERSAMPLE - 1))
                    begin
                        os_count      <= '0;
                        recieved_flag <= 1'b0;
                        active_flag   <= 1'b0;
                        state         <= IDLE;
                    end
                    else
                    begin
                        os_count <= os_count + 1'b1;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Frame handoff only happens inside an active reception
    a_recv_in_active: assert property (
        @(posedge baud_clk) disable iff (!reset_n)
        recieved_flag |-> active_flag
    );

    // State register holds a legal encoding
    a_state_legal: assert property (
        @(posedge baud_clk) disable iff (!reset_n)
        state inside {IDLE, CENTER, FRAME, HOLD}
    );

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx
    import uart_rx_pkg::*;
(
    input  logic                  baud_clk,
    input  logic                  reset_n,
    input  logic                  data_tx,
    input  parity_mode_t          parity_mode,
    output logic                  active_flag,
    output logic                  data_valid,
    output logic [DATA_BITS-1:0]  rx_data,
    output logic                  parity_err_flag,
    output logic                  frame_err_flag,
    output logic [STAT_WIDTH-1:0] frame_count,
    output logic [STAT_WIDTH-1:0] parity_err_count,
    output logic [STAT_WIDTH-1:0] frame_err_count
);

    // Handoff from the shift register to the datapath
    logic                  recieved_flag;
    logic [FRAME_BITS-1:0] data_parll;
    logic                  parity_error;

    // Serial capture FSM
    sipo u_sipo (
        .baud_clk      (baud_clk),
        .reset_n       (reset_n),
        .data_tx       (data_tx),
        .active_flag   (active_flag),
        .recieved_flag (recieved_flag),
        .data_parll    (data_parll)
    );

    // Combinational parity check on the held frame
    parity_check u_parity_check (
        .data_parll   (data_parll),
        .parity_mode  (parity_mode),
        .parity_error (parity_error)
    );

    // Start/stop check and byte output
    deframe u_deframe (
        .baud_clk        (baud_clk),
        .reset_n         (reset_n),
        .recieved_flag   (recieved_flag),
        .data_parll      (data_parll),
        .parity_error    (parity_error),
        .data_valid      (data_valid),
        .rx_data         (rx_data),
        .parity_err_flag (parity_err_flag),
        .frame_err_flag  (frame_err_flag)
    );

    // Frame and error statistics
    rx_error_stats u_rx_error_stats (
        .baud_clk         (baud_clk),
        .reset_n          (reset_n),
        .data_valid       (data_valid),
        .parity_err_flag  (parity_err_flag),
        .frame_err_flag   (frame_err_flag),
        .frame_count      (frame_count),
        .parity_err_count (parity_err_count),
        .frame_err_count  (frame_err_count)
    );

endmodule

/* hdl/uart_rx_pkg.sv */
package uart_rx_pkg;

    // Frame layout is start, eight data bits LSB first, parity and stop
    localparam int FRAME_BITS = 11;
    localparam int DATA_BITS = 8;

    // Baud clock runs at sixteen times the bit rate
    localparam int OVERSAMPLE = 16;
    // Cycles from the start edge to the middle of the start bit
    localparam int HALF_BIT = 8;

    // Counter widths inside the receiver FSM
    localparam int OS_WIDTH = $clog2(OVERSAMPLE);
    localparam int BIT_WIDTH = $clog2(FRAME_BITS);

    // Width of each statistics counter
    localparam int STAT_WIDTH = 8;

    // Receiver FSM states
    typedef enum logic [1:0] {
        IDLE,
        CENTER,
        FRAME,
        HOLD
    } rx_state_t;

    // Parity selection for the frame checker
    typedef enum logic {
        PARITY_EVEN,
        PARITY_ODD
    } parity_mode_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module uart_rx_tb \
    -Mdir "$BUILD_DIR" -o uart_rx_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/uart_rx_tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tb.f */
hdl/uart_rx_pkg.sv
hdl/sipo.sv
hdl/parity_check.sv
hdl/deframe.sv
hdl/rx_error_stats.sv
hdl/uart_rx.sv
tests/uart_rx_tb.sv

/* tests/uart_rx_tb.sv */
`timescale 1ns/1ns

module uart_rx_tb
    import uart_rx_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int CLEAN_FRAMES = 8;
    // Clean frames in both modes, two parity errors, three framing cases
    localparam int N_FRAMES = 2 * CLEAN_FRAMES + 5;
    // Edges from start detection to the data_valid update, and to the end of HOLD
    localparam int VALID_DELAY = HALF_BIT + (FRAME_BITS - 1) * OVERSAMPLE + 2;
    localparam int HOLD_END = VALID_DELAY - 1 + OVERSAMPLE;
    localparam int WATCHDOG_NS = N_FRAMES * FRAME_BITS * OVERSAMPLE * CLK_PERIOD * 2;
    localparam int IDLE_LIMIT = 2 * FRAME_BITS * OVERSAMPLE;

    logic                  baud_clk = 1'b0;
    logic                  reset_n = 1'b0;
    // Serial line idles high
    logic                  data_tx = 1'b1;
    parity_mode_t          parity_mode = PARITY_EVEN;
    logic                  active_flag;
    logic                  data_valid;
    logic [DATA_BITS-1:0]  rx_data;
    logic                  parity_err_flag;
    logic                  frame_err_flag;
    logic [STAT_WIDTH-1:0] frame_count;
    logic [STAT_WIDTH-1:0] parity_err_count;
    logic [STAT_WIDTH-1:0] frame_err_count;

    // Expected state of the frame in flight
    int                    cycle = 0;
    int                    t0_cycle = 0;
    logic                  started = 1'b0;
    logic [DATA_BITS-1:0]  exp_data = '0;
    logic                  exp_perr = 1'b0;
    logic                  exp_ferr = 1'b0;
    logic [STAT_WIDTH-1:0] exp_frames = '0;
    logic [STAT_WIDTH-1:0] exp_perr_count = '0;
    logic [STAT_WIDTH-1:0] exp_ferr_count = '0;
    logic                  active_expected;
    logic                  valid_expected;

    int errors = 0;
    int timeouts = 0;
    int test_base = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    uart_rx uut (
        .baud_clk         (baud_clk),
        .reset_n          (reset_n),
        .data_tx          (data_tx),
        .parity_mode      (parity_mode),
        .active_flag      (active_flag),
        .data_valid       (data_valid),
        .rx_data          (rx_data),
        .parity_err_flag  (parity_err_flag),
        .frame_err_flag   (frame_err_flag),
        .frame_count      (frame_count),
        .parity_err_count (parity_err_count),
        .frame_err_count  (frame_err_count)
    );

    always #(CLK_PERIOD / 2) baud_clk = ~baud_clk;

    // Free-running edge count for the timing windows
    always @(posedge baud_clk)
    begin
        cycle <= cycle + 1;
    end

    // t0_cycle is the sampled count on the edge where the FSM sees the low line
    assign active_expected = started && cycle > t0_cycle && cycle <= t0_cycle + HOLD_END;
    assign valid_expected = started && cycle == t0_cycle + VALID_DELAY + 1;

    // Error flags and counters quiet until the first start bit
    a_quiet: assert property (@(posedge baud_clk) disable iff (!reset_n)
        !started |-> {parity_err_flag, frame_err_flag, frame_count, parity_err_count,
                      frame_err_count} == '0)
        else report_mismatch("flags and counters", 0, 32'($sampled({parity_err_flag,
            frame_err_flag, frame_count, parity_err_count, frame_err_count})));
    a_active: assert property (@(posedge baud_clk) disable iff (!reset_n)
        active_flag == active_expected)
        else report_mismatch("active_flag", 32'($sampled(active_expected)),
                             32'($sampled(active_flag)));
    // Exactly one pulse at a fixed distance from start detection
    a_valid: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid == valid_expected)
        else report_mismatch("data_valid", 32'($sampled(valid_expected)),
                             32'($sampled(data_valid)));
    a_rx_data: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid |-> rx_data == exp_data)
        else report_mismatch("rx_data", 32'($sampled(exp_data)), 32'($sampled(rx_data)));
    a_parity_flag: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid |-> parity_err_flag == exp_perr)
        else report_mismatch("parity_err_flag", 32'($sampled(exp_perr)),
                             32'($sampled(parity_err_flag)));
    a_frame_flag: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid |-> frame_err_flag == exp_ferr)
        else report_mismatch("frame_err_flag", 32'($sampled(exp_ferr)),
                             32'($sampled(frame_err_flag)));
    // Counters settle one edge after the pulse
    a_frame_count: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid |=> frame_count == exp_frames)
        else report_mismatch("frame_count", 32'($sampled(exp_frames)),
                             32'($sampled(frame_count)));
    a_perr_count: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid |=> parity_err_count == exp_perr_count)
        else report_mismatch("parity_err_count", 32'($sampled(exp_perr_count)),
                             32'($sampled(parity_err_count)));
    a_ferr_count: assert property (@(posedge baud_clk) disable iff (!reset_n)
        data_valid |=> frame_err_count == exp_ferr_count)
        else report_mismatch("frame_err_count", 32'($sampled(exp_ferr_count)),
                             32'($sampled(frame_err_count)));

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s expected %h got %h at %0t ns", name, expected, actual, $time);
        errors = errors + 1;
    endtask

    task automatic end_test(input string name);
        int failures;
        failures = errors + timeouts - test_base;
        test_base = errors + timeouts;
        if (failures == 0)
        begin
            tests_passed = tests_passed + 1;
        end
        else
        begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %s: %0d failed check(s)", name, failures);
    endtask

    task automatic set_parity_mode(input parity_mode_t mode);
        @(posedge baud_clk);
        parity_mode <= mode;
    endtask

    // start_bit 1 gives a 4-cycle low pulse that reads high at mid-bit
    task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic flip_parity,
                              input logic start_bit, input logic stop_bit);
        logic                  parity_bit;
        logic                  perr;
        logic                  ferr;
        logic [FRAME_BITS-1:0] frame;
        int                    low_cycles;
        int                    i;
        int                    waited;
        @(posedge baud_clk);
        // Even mode makes the count of ones even, odd mode makes it odd
        parity_bit = ((parity_mode == PARITY_EVEN) ? ^data : ~^data) ^ flip_parity;
        frame = {stop_bit, parity_bit, data, start_bit};
        // Injected errors are the expected flags
        perr = flip_parity;
        ferr = start_bit | ~stop_bit;
        exp_data <= data;
        exp_perr <= perr;
        exp_ferr <= ferr;
        exp_frames <= exp_frames + STAT_WIDTH'(1);
        exp_perr_count <= exp_perr_count + STAT_WIDTH'(perr);
        exp_ferr_count <= exp_ferr_count + STAT_WIDTH'(ferr);
        started <= 1'b1;
        // Low line is seen by the FSM one edge later
        t0_cycle <= cycle + 1;
        data_tx <= 1'b0;
        low_cycles = start_bit ? 4 : OVERSAMPLE;
        repeat (low_cycles) @(posedge baud_clk);
        data_tx <= 1'b1;
        repeat (OVERSAMPLE - low_cycles) @(posedge baud_clk);
        for (i = 1; i < FRAME_BITS; i++)
        begin
            data_tx <= frame[i];
            repeat (OVERSAMPLE) @(posedge baud_clk);
        end
        data_tx <= 1'b1;
        // Frame is done once the receiver is back in IDLE
        waited = 0;
        while (active_flag && waited < IDLE_LIMIT)
        begin
            @(posedge baud_clk);
            waited++;
        end
        if (active_flag)
        begin
            $display("Receiver still active %0d cycles after the stop bit", IDLE_LIMIT);
            timeouts = timeouts + 1;
        end
    endtask

    initial
    begin
        void'($urandom(32'h0626_7112));
        repeat (4) @(posedge baud_clk);
        reset_n <= 1'b1;

        // Idle line after reset
        repeat (4 * OVERSAMPLE) @(posedge baud_clk);
        end_test("reset state");

        set_parity_mode(PARITY_EVEN);
        repeat (CLEAN_FRAMES) send_frame(DATA_BITS'($urandom), 1'b0, 1'b0, 1'b1);
        end_test("clean frames, even parity");

        set_parity_mode(PARITY_ODD);
        repeat (CLEAN_FRAMES) send_frame(DATA_BITS'($urandom), 1'b0, 1'b0, 1'b1);
        end_test("clean frames, odd parity");

        // Inverted parity bit in each mode
        send_frame(DATA_BITS'($urandom), 1'b1, 1'b0, 1'b1);
        set_parity_mode(PARITY_EVEN);
        send_frame(DATA_BITS'($urandom), 1'b1, 1'b0, 1'b1);
        end_test("parity errors");

        // Low stop bit, short start pulse, then both errors in one frame
        send_frame(DATA_BITS'($urandom), 1'b0, 1'b0, 1'b0);
        send_frame(DATA_BITS'($urandom), 1'b0, 1'b1, 1'b1);
        send_frame(DATA_BITS'($urandom), 1'b1, 1'b0, 1'b0);
        end_test("framing errors");

        repeat (2) @(posedge baud_clk);
        $display("Tests ok: %0d, tests with errors: %0d, failed checks: %0d",
                 tests_passed, tests_failed, errors + timeouts);
        if (tests_failed == 0 && errors + timeouts == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog allows twice the nominal length of all frames
    initial
    begin
        #(WATCHDOG_NS);
        $display("Simulation did not finish within %0d ns and was stopped", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule
